// ==== filelist.f ====
+incdir+include
src/lop_pkg.sv
src/lop_indicator_stage.sv
src/lop_lzc_stage.sv
src/lop_shift_stage.sv
src/lop_top.sv
tb/lop_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the leading-one predictor testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module lop_tb \
  -f filelist.f

out=$(./obj_dir/Vlop_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Testbench passed'; then
  exit 0
else
  exit 1
fi

// ==== include/lop_ref.svh ====
/*
  Reference model of the predictor for the testbench. Include inside the
  testbench module and call expected_pred() on each accepted request.
*/
`ifndef LOP_REF_SVH
`define LOP_REF_SVH

// indicator bit from own g/z, the propagate above and g/z of the bit below
function automatic logic indicator_bit(logic t_up, logic g, logic z,
                                       logic g_dn, logic z_dn);
  if (t_up) begin
    return (g & ~z_dn) | (z & ~g_dn);
  end
  return (g & ~g_dn) | (z & ~z_dn);
endfunction

// masked indicator vector with virtual bits at both edges
function automatic lop_pkg::sig_t indicator_code(lop_pkg::lop_req_t req);
  logic [lop_pkg::sig_w:0]  t_ext;
  logic [lop_pkg::sig_w:-1] g_ext;
  logic [lop_pkg::sig_w:-1] z_ext;
  lop_pkg::sig_t            code;

  // above the top bit the propagate is act_sub
  t_ext = {req.act_sub, req.src0 ^ req.src1};
  // below bit 0 sits a bit that is never generate and is zero for an add
  g_ext = {1'b0, req.src0 & req.src1, 1'b0};
  z_ext = {1'b0, ~req.src0 & ~req.src1, ~req.act_sub};
  for (int i = 0; i < lop_pkg::sig_w; i++) begin
    code[i] = indicator_bit(t_ext[i+1], g_ext[i], z_ext[i], g_ext[i-1], z_ext[i-1]);
  end
  return code | req.mask;
endfunction

function automatic int sat_sub(int value, int offset);
  return (value > offset) ? value - offset : 0;
endfunction

// expected predictions for one request
function automatic lop_pkg::lop_pred_t expected_pred(lop_pkg::lop_req_t req);
  lop_pkg::sig_t      code;
  lop_pkg::lop_pred_t pred;
  int                 lz_full;
  int                 lz_low;

  code    = indicator_code(req);
  pred    = '0;
  lz_full = -1;
  lz_low  = -1;

  // scan down from the top for the first one
  for (int i = lop_pkg::sig_msb; i >= 0; i--) begin
    if (code[i] && lz_full < 0) begin
      lz_full = lop_pkg::sig_msb - i;
    end
    if (i < lop_pkg::low_w && code[i] && lz_low < 0) begin
      lz_low = lop_pkg::low_w - 1 - i;
    end
  end

  pred.none_d = (lz_full < 0);
  pred.none_s = (lz_low < 0);
  if (lz_full >= 0) begin
    pred.pred_d = lop_pkg::dcnt_t'(sat_sub(lz_full, 1));
  end
  if (lz_low >= 0) begin
    pred.pred_s  = lop_pkg::scnt_t'(sat_sub(lz_low, 1));
    pred.pred_h  = lop_pkg::scnt_t'(sat_sub(lz_low, lop_pkg::h_offset));
    pred.pred_bh = lop_pkg::scnt_t'(sat_sub(lz_low, lop_pkg::bh_offset));
  end
  return pred;
endfunction

`endif

// ==== tb/lop_tb.sv ====
/*
  Testbench for the leading-one predictor pipeline. Runs random, one-hot mask,
  empty-code, stall and mid-stream reset sequences and scores every output.
*/
`default_nettype none

module lop_tb;

  // requests per phase set the timeout limit
  localparam int n_random    = 200;
  localparam int n_empty     = 4;
  localparam int n_stall     = 300;
  localparam int n_flush     = 3;
  localparam int n_reset     = 40;
  localparam int n_total     = n_random + lop_pkg::sig_w + n_empty + n_stall + n_flush + n_reset;
  localparam int cycle_limit = 2 * n_total + 200;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               in_valid;
  logic               in_ready;
  lop_pkg::lop_req_t  in_data;
  logic               out_valid;
  logic               out_ready;
  lop_pkg::lop_pred_t out_data;

  int                 seed = 32'h359d;
  int                 errors = 0;
  int                 cycles = 0;
  int                 accepted = 0;
  bit                 ready_random = 1'b0;
  lop_pkg::lop_pred_t exp_q[$];
  logic               stalled = 1'b0;
  lop_pkg::lop_pred_t held;

  `include "lop_ref.svh"

  lop_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  always #10 clk = ~clk;

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected) begin
      errors++;
      $display("Fail at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // scoreboard samples both ends on the rising edge
  always @(posedge clk) begin : scoreboard
    lop_pkg::lop_pred_t expected;
    if (!rst_n) begin
      exp_q.delete();
      stalled = 1'b0;
    end else begin
      if (in_valid && in_ready) begin
        exp_q.push_back(expected_pred(in_data));
        accepted++;
      end
      if (stalled) begin
        check(64'(out_valid), 64'(1), "out_valid dropped while stalled");
        check(64'(out_data), 64'(held), "out_data changed while stalled");
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("output at time %0t arrived with no request outstanding", $time);
        end else begin
          expected = exp_q.pop_front();
          check(64'(out_data), 64'(expected), "prediction mismatch");
        end
      end
      stalled = out_valid && !out_ready;
      held    = out_data;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles, %0d errors so far",
               cycle_limit, errors);
      $display("Testbench failed");
      $finish;
    end
  end

  // advance to the falling edge and redraw out_ready when stalls are on
  task automatic tick();
    logic [31:0] r;
    @(negedge clk);
    if (ready_random) begin
      r = $random(seed);
      out_ready = (r[1:0] != 2'b00);
    end
  endtask

  function automatic lop_pkg::sig_t rand_sig();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[lop_pkg::sig_w-1:0];
  endfunction

  function automatic lop_pkg::lop_req_t rand_req();
    lop_pkg::lop_req_t req;
    logic [31:0]       r;
    r        = $random(seed);
    req.src0 = rand_sig();
    // close-path operands often agree in their upper bits
    req.src1    = r[1] ? (req.src0 ^ (rand_sig() >> r[7:2])) : rand_sig();
    req.mask    = '0;
    req.act_sub = r[0];
    return req;
  endfunction

  // hold the request until the scoreboard has seen it accepted
  task automatic send(input lop_pkg::lop_req_t req);
    int target;
    target   = accepted + 1;
    in_valid = 1'b1;
    in_data  = req;
    while (accepted < target) begin
      tick();
    end
    in_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 40) begin
      tick();
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d accepted requests never produced an output", exp_q.size());
    end
  endtask

  initial begin
    lop_pkg::lop_req_t req;
    logic [31:0]       r;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b1;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    check(64'(in_ready), 64'(1), "in_ready low after reset");
    check(64'(out_valid), 64'(0), "out_valid high after reset");

    // random operands for add and subtract
    repeat (n_random) send(rand_req());
    drain();

    // one-hot mask over zero operands walks every boundary
    for (int i = 0; i < lop_pkg::sig_w; i++) begin
      req      = '0;
      req.mask = lop_pkg::sig_t'(1) << i;
      send(req);
    end
    drain();

    // empty code followed by codes empty only in the low window
    req = '0;
    send(req);
    req.mask = lop_pkg::sig_t'(1) << lop_pkg::low_w;
    send(req);
    req.mask = lop_pkg::sig_t'(1) << 40;
    send(req);
    req.mask = lop_pkg::sig_t'(1) << lop_pkg::sig_msb;
    send(req);
    drain();

    // back-pressure and gaps on the input
    ready_random = 1'b1;
    repeat (n_stall) begin
      r = $random(seed);
      if (r[1:0] == 2'b00) begin
        tick();
      end
      send(rand_req());
    end
    drain();
    ready_random = 1'b0;

    // fill the pipe under a full stall and then reset it
    out_ready = 1'b0;
    repeat (n_flush) send(rand_req());
    rst_n = 1'b0;
    tick();
    tick();
    check(64'(out_valid), 64'(0), "out_valid high after mid-stream reset");
    rst_n     = 1'b1;
    out_ready = 1'b1;
    repeat (n_reset) send(rand_req());
    drain();

    $display("run complete: %0d requests accepted, %0d errors", accepted, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/lop_top.sv ====
/*
  Leading-one predictor for the close path of the FP adder, three register
  stages deep with a valid/ready handshake on both ends.
*/
`default_nettype none

module lop_top (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              in_valid,
  output logic                   in_ready,
  input  wire lop_pkg::lop_req_t in_data,
  output logic                   out_valid,
  input  wire logic              out_ready,
  output lop_pkg::lop_pred_t     out_data
);

  // indicator to lzc
  logic              ind_valid;
  logic              ind_ready;
  lop_pkg::lop_ind_t ind_data;

  // lzc to shift
  logic             lz_valid;
  logic             lz_ready;
  lop_pkg::lop_lz_t lz_data;

  lop_indicator_stage u_indicator (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (ind_valid),
    .out_ready (ind_ready),
    .out_data  (ind_data)
  );

  lop_lzc_stage u_lzc (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (ind_valid),
    .in_ready  (ind_ready),
    .in_data   (ind_data),
    .out_valid (lz_valid),
    .out_ready (lz_ready),
    .out_data  (lz_data)
  );

  lop_shift_stage u_shift (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (lz_valid),
    .in_ready  (lz_ready),
    .in_data   (lz_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire

// ==== src/lop_shift_stage.sv ====
/*
  Third pipeline stage: turns the leading-zero counts into normalization
  shift predictions for double, single, half and bfloat16, then registers them.
*/
`default_nettype none

module lop_shift_stage (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             in_valid,
  output logic                  in_ready,
  input  wire lop_pkg::lop_lz_t in_data,
  output logic                  out_valid,
  input  wire logic             out_ready,
  output lop_pkg::lop_pred_t    out_data
);

  lop_pkg::lop_pred_t pred_next;

  // each prediction is a count minus an offset, clamped at zero
  always_comb begin
    pred_next        = '0;
    pred_next.none_d = !in_data.any_full;
    pred_next.none_s = !in_data.any_low;

    if (in_data.any_full && in_data.lz_full != '0) begin
      pred_next.pred_d = in_data.lz_full - 1'b1;
    end

    if (in_data.any_low) begin
      if (in_data.lz_low != '0) begin
        pred_next.pred_s = in_data.lz_low - 1'b1;
      end
      // half keeps 11 bits of the low window
      if (in_data.lz_low > lop_pkg::scnt_t'(lop_pkg::h_offset)) begin
        pred_next.pred_h = in_data.lz_low - lop_pkg::scnt_t'(lop_pkg::h_offset);
      end
      // bfloat16 keeps 8
      if (in_data.lz_low > lop_pkg::scnt_t'(lop_pkg::bh_offset)) begin
        pred_next.pred_bh = in_data.lz_low - lop_pkg::scnt_t'(lop_pkg::bh_offset);
      end
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= pred_next;
    end
  end

  // larger offset never gives the larger shift
  bh_not_above_h: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> out_data.pred_bh <= out_data.pred_h
  );

endmodule

`default_nettype wire

// ==== src/lop_lzc_stage.sv ====
/*
  Second pipeline stage: leading-zero counts of the indicator vector over the
  full 54-bit window and the low 25-bit window, with window-not-empty flags.
*/
`default_nettype none

module lop_lzc_stage (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              in_valid,
  output logic                   in_ready,
  input  wire lop_pkg::lop_ind_t in_data,
  output logic                   out_valid,
  input  wire logic              out_ready,
  output lop_pkg::lop_lz_t       out_data
);

  lop_pkg::lop_lz_t lz_next;

  // full window count where the highest set bit wins
  always_comb begin
    lz_next.lz_full  = '0;
    lz_next.any_full = 1'b0;
    for (int i = 0; i < lop_pkg::sig_w; i++) begin
      if (in_data.code[i]) begin
        lz_next.lz_full  = lop_pkg::dcnt_t'(lop_pkg::sig_msb - i);
        lz_next.any_full = 1'b1;
      end
    end
  end

  // low window count as seen by single, half and bfloat16
  always_comb begin
    lz_next.lz_low  = '0;
    lz_next.any_low = 1'b0;
    for (int i = 0; i < lop_pkg::low_w; i++) begin
      if (in_data.code[i]) begin
        lz_next.lz_low  = lop_pkg::scnt_t'(lop_pkg::low_w - 1 - i);
        lz_next.any_low = 1'b1;
      end
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= lz_next;
    end
  end

  // counts stay inside their windows
  full_count_in_window: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && out_data.any_full |-> out_data.lz_full < lop_pkg::sig_w
  );

  low_count_in_window: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && out_data.any_low |-> out_data.lz_low < lop_pkg::low_w
  );

endmodule

`default_nettype wire

// ==== src/lop_indicator_stage.sv ====
/*
  First pipeline stage: builds the close-path leading-one indicator vector
  from two aligned significands, ORs in the mask and registers the result.
*/
`default_nettype none

module lop_indicator_stage (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              in_valid,
  output logic                   in_ready,
  input  wire lop_pkg::lop_req_t in_data,
  output logic                   out_valid,
  input  wire logic              out_ready,
  output lop_pkg::lop_ind_t      out_data
);

  lop_pkg::sig_t t;
  lop_pkg::sig_t g;
  lop_pkg::sig_t z;
  lop_pkg::sig_t f;
  lop_pkg::lop_ind_t ind_next;

  // propagate, generate and zero terms per bit
  assign t = in_data.src0 ^ in_data.src1;
  assign g = in_data.src0 & in_data.src1;
  assign z = ~in_data.src0 & ~in_data.src1;

  // first one of the result lands at the flagged bit or one below it
  always_comb begin
    // act_sub stands in for the missing propagate above the top bit
    if (in_data.act_sub) begin
      f[lop_pkg::sig_msb] = (g[lop_pkg::sig_msb] & ~z[lop_pkg::sig_msb-1]) |
                            (z[lop_pkg::sig_msb] & ~g[lop_pkg::sig_msb-1]);
    end else begin
      f[lop_pkg::sig_msb] = (g[lop_pkg::sig_msb] & ~g[lop_pkg::sig_msb-1]) |
                            (z[lop_pkg::sig_msb] & ~z[lop_pkg::sig_msb-1]);
    end

    // middle bits depend on the next higher propagate
    for (int i = 1; i < lop_pkg::sig_msb; i++) begin
      if (t[i+1]) begin
        f[i] = (g[i] & ~z[i-1]) | (z[i] & ~g[i-1]);
      end else begin
        f[i] = (g[i] & ~g[i-1]) | (z[i] & ~z[i-1]);
      end
    end

    // bit 0 has no lower neighbour
    if (t[1]) begin
      f[0] = (g[0] & in_data.act_sub) | z[0];
    end else begin
      f[0] = (z[0] & in_data.act_sub) | g[0];
    end
  end

  assign ind_next.code = f | in_data.mask;

  // single register slot
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= ind_next;
    end
  end

  // a stalled item keeps its slot and its payload
  hold_when_stalled: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  );

endmodule

`default_nettype wire

// ==== src/lop_pkg.sv ====
/*
  Shared widths, shift offsets and stage payload structs for the leading-one
  predictor pipeline. Referenced by scoped name from the RTL and the testbench.
*/
`default_nettype none

package lop_pkg;

  // full significand window and its low single precision part
  localparam int sig_w   = 54;
  localparam int sig_msb = sig_w - 1;
  localparam int low_w   = 25;

  // count widths for double and the narrower formats
  localparam int dcnt_w = 6;
  localparam int scnt_w = 5;

  // leading zeros of the low window dropped by the half and bfloat16 shifts
  localparam int h_offset  = 14;
  localparam int bh_offset = 17;

  typedef logic [sig_w-1:0]  sig_t;
  typedef logic [dcnt_w-1:0] dcnt_t;
  typedef logic [scnt_w-1:0] scnt_t;

  // request into the indicator stage
  typedef struct packed {
    sig_t src0;
    sig_t src1;
    sig_t mask;
    logic act_sub;
  } lop_req_t;

  // masked indicator vector
  typedef struct packed {
    sig_t code;
  } lop_ind_t;

  // leading-zero counts that read zero for an empty window
  typedef struct packed {
    dcnt_t lz_full;
    scnt_t lz_low;
    logic  any_full;
    logic  any_low;
  } lop_lz_t;

  // per-format normalization shift predictions
  typedef struct packed {
    dcnt_t pred_d;
    scnt_t pred_s;
    scnt_t pred_h;
    scnt_t pred_bh;
    logic  none_d;
    logic  none_s;
  } lop_pred_t;

endpackage

`default_nettype wire
